// File: all.f
+incdir+hdl
hdl/mips_pkg.sv
hdl/fetch_stage.sv
hdl/register_file.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mips_pipeline.sv
verification/tb_clock_gen.sv
verification/tb_mips_pipeline.sv

// File: Makefile
TOP = tb_mips_pipeline

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Simulation passed$$" sim.log

lint:
	verilator --lint-only --timing -Wall -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: verification/tb_mips_pipeline.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_defines.svh"

module tb_mips_pipeline;

    // --------------------------------------------------
    // Program sizes, also used by the watchdog
    // --------------------------------------------------
    localparam int IMM_LEN   = 40;
    localparam int SEED_REGS = 7;           // Registers preset before R-type ops
    localparam int RT_COUNT  = 30;
    localparam int RTYPE_LEN = 2 * SEED_REGS + RT_COUNT + 1;
    localparam int ZERO_LEN  = 13;
    localparam int HALT_AT   = 4;           // HALT word index in the stepped program
    localparam int STEP_LEN  = HALT_AT + 6;
    localparam int TOTAL_LEN = IMM_LEN + RTYPE_LEN + ZERO_LEN + STEP_LEN;
    localparam int WATCHDOG_CYCLES = TOTAL_LEN * 10 + 500;
    localparam logic [`REG_W-1:0] HALT_WORD = {`OP_HALT, 26'd0};

    logic                clk;
    logic                rst_n;
    logic                restart;
    logic                dunit_clk_en;
    logic                dunit_reset_pc;
    logic                dunit_w_mem;
    logic [`REG_W-1:0]   dunit_addr;
    logic [`REG_W-1:0]   dunit_data;
    logic [`REG_W-1:0]   dunit_reg;
    logic                halt;
    logic                reg_chk;       // Compare readback this cycle
    logic [`REG_W-1:0]   exp_reg;
    logic                halt_chk;      // Compare o_halt this cycle
    logic                exp_halt;
    int                  reg_errs;
    int                  halt_errs;
    integer              seed = 32'hbd79;
    logic [`REG_W-1:0]   prog [$];      // Program being run
    logic [`REG_W-1:0]   ref_regs [32]; // Reference model state

    tb_clock_gen u_clock_gen (
        .i_restart(restart),
        .o_clk    (clk),
        .o_rst_n  (rst_n)
    );

    mips_pipeline DUT (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .i_dunit_clk_en  (dunit_clk_en),
        .i_dunit_reset_pc(dunit_reset_pc),
        .i_dunit_w_mem   (dunit_w_mem),
        .i_dunit_addr    (dunit_addr),
        .i_dunit_data    (dunit_data),
        .o_dunit_reg     (dunit_reg),
        .o_halt          (halt)
    );

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    a_reg_readback : assert property (
        @(posedge clk) disable iff (!rst_n)
        reg_chk |-> (dunit_reg == exp_reg)
    ) else begin
        reg_errs++;
        $display("[FAIL] t=%0t o_dunit_reg r%0d: expected %08h, actual %08h",
                 $time, dunit_addr[4:0], exp_reg, dunit_reg);
    end

    a_halt_state : assert property (
        @(posedge clk) disable iff (!rst_n)
        halt_chk |-> (halt == exp_halt)
    ) else begin
        halt_errs++;
        $display("[FAIL] t=%0t o_halt: expected %0b, actual %0b", $time, exp_halt, halt);
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    // --------------------------------------------------
    // Encoding and reference model
    // --------------------------------------------------
    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [`REG_W-1:0] make_rtype(input logic [4:0] rs, input logic [4:0] rt,
                                                     input logic [4:0] rd, input logic [5:0] fn);
        return {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [`REG_W-1:0] make_itype(input logic [5:0] op, input logic [4:0] rs,
                                                     input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Runs prog one instruction at a time until HALT
    task automatic run_reference();
        logic [`REG_W-1:0]   w;
        logic [`REG_W-1:0]   a;
        logic [`REG_W-1:0]   b;
        logic [`REG_W-1:0]   res;
        logic [`RADDR_W-1:0] dst;
        logic                wr;
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;
        end
        for (int i = 0; i < prog.size(); i++) begin
            w   = prog[i];
            a   = ref_regs[w[25:21]];
            b   = ref_regs[w[20:16]];
            dst = w[20:16];                 // rt for immediates
            wr  = 1'b1;
            res = '0;
            case (w[31:26])
                `OP_RTYPE: begin
                    dst = w[15:11];
                    case (w[5:0])
                        `FN_ADDU: res = a + b;
                        `FN_SUBU: res = a - b;
                        `FN_AND:  res = a & b;
                        `FN_OR:   res = a | b;
                        `FN_XOR:  res = a ^ b;
                        `FN_SLT:  res = {31'd0, $signed(a) < $signed(b)};
                        default:  wr  = 1'b0;
                    endcase
                end
                `OP_ADDIU: res = a + {{16{w[15]}}, w[15:0]};
                `OP_ANDI:  res = a & {16'd0, w[15:0]};
                `OP_ORI:   res = a | {16'd0, w[15:0]};
                `OP_LUI:   res = {w[15:0], 16'd0};
                `OP_HALT:  break;           // Nothing after it runs
                default:   wr = 1'b0;
            endcase
            if (wr && (dst != '0)) begin
                ref_regs[dst] = res;
            end
        end
    endtask

    // --------------------------------------------------
    // Stimulus tasks
    // --------------------------------------------------
    task automatic restart_dut();
        restart = 1'b1;
        @(negedge clk);
        restart = 1'b0;
        while (!rst_n) begin
            @(negedge clk);
        end
    endtask

    task automatic compare_registers(input logic halt_expected);
        exp_halt = halt_expected;
        halt_chk = 1'b1;
        for (int r = 0; r < 32; r++) begin
            dunit_addr = r;                 // Debug readback index
            exp_reg    = ref_regs[r];
            reg_chk    = 1'b1;
            @(negedge clk);
        end
        reg_chk    = 1'b0;
        halt_chk   = 1'b0;
        dunit_addr = '0;
    endtask

    task automatic run_program(input bit stepped);
        run_reference();
        for (int i = 0; i < prog.size(); i++) begin
            dunit_w_mem = 1'b1;             // Pipeline stopped while loading
            dunit_addr  = i;
            dunit_data  = prog[i];
            @(negedge clk);
        end
        dunit_w_mem    = 1'b0;
        dunit_reset_pc = 1'b1;
        @(negedge clk);
        dunit_reset_pc = 1'b0;
        if (stepped) begin
            for (int k = 1; k <= STEP_LEN; k++) begin
                dunit_clk_en = 1'b1;        // Enabled edge k
                halt_chk     = 1'b0;
                @(negedge clk);
                dunit_clk_en = 1'b0;
                exp_halt     = (k >= HALT_AT + 2);
                halt_chk     = 1'b1;        // Checked on a frozen edge
                @(negedge clk);
            end
        end else begin
            dunit_clk_en = 1'b1;
            while (!halt) begin
                @(negedge clk);
            end
            dunit_clk_en = 1'b0;
        end
        compare_registers(1'b1);
    endtask

    // --------------------------------------------------
    // Program builders
    // --------------------------------------------------
    task automatic build_imm_program();
        logic [5:0] ops [4];
        ops[0] = `OP_ADDIU;
        ops[1] = `OP_ANDI;
        ops[2] = `OP_ORI;
        ops[3] = `OP_LUI;
        prog.delete();
        for (int i = 0; i < IMM_LEN - 1; i++) begin
            prog.push_back(make_itype(ops[rand_below(4)], 5'(rand_below(16)),
                                      5'(rand_below(16)), 16'($random(seed))));
        end
        prog.push_back(HALT_WORD);
    endtask

    task automatic build_rtype_program();
        logic [5:0] fns [6];
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] prev_rd;
        fns[0] = `FN_ADDU;
        fns[1] = `FN_SUBU;
        fns[2] = `FN_AND;
        fns[3] = `FN_OR;
        fns[4] = `FN_XOR;
        fns[5] = `FN_SLT;
        prog.delete();
        for (int i = 1; i <= SEED_REGS; i++) begin
            prog.push_back(make_itype(`OP_LUI, 5'd0, 5'(i), 16'($random(seed))));
            prog.push_back(make_itype(`OP_ORI, 5'(i), 5'(i), 16'($random(seed))));
        end
        prev_rd = 5'(SEED_REGS);
        for (int i = 0; i < RT_COUNT; i++) begin
            rs = (rand_below(2) == 0) ? prev_rd : 5'(1 + rand_below(SEED_REGS));
            rt = (rand_below(2) == 0) ? prev_rd : 5'(1 + rand_below(SEED_REGS));
            rd = 5'(1 + rand_below(SEED_REGS));
            prog.push_back(make_rtype(rs, rt, rd, (i < 6) ? fns[i] : fns[rand_below(6)]));
            prev_rd = rd;                   // Next op often reads it at once
        end
        prog.push_back(HALT_WORD);
    endtask

    task automatic build_zero_program();
        prog.delete();
        for (int i = 1; i <= 3; i++) begin
            prog.push_back(make_itype(`OP_ADDIU, 5'd0, 5'(i), 16'($random(seed))));
        end
        prog.push_back(make_itype(`OP_ADDIU, 5'd1, 5'd0, 16'h1234));   // $zero as target
        prog.push_back(make_rtype(5'd1, 5'd2, 5'd0, `FN_ADDU));
        prog.push_back(make_itype(`OP_ORI, 5'd2, 5'd0, 16'hffff));
        prog.push_back(make_itype(`OP_LUI, 5'd0, 5'd0, 16'h8000));
        prog.push_back(make_itype(6'h23, 5'd1, 5'd2, 16'h0004));       // LW opcode
        prog.push_back(make_itype(6'h08, 5'd1, 5'd3, 16'h0001));       // ADDI opcode
        prog.push_back(make_rtype(5'd1, 5'd2, 5'd4, 6'h00));           // SLL funct
        prog.push_back(make_rtype(5'd1, 5'd2, 5'd1, 6'h27));           // NOR funct
        prog.push_back(make_rtype(5'd0, 5'd1, 5'd5, `FN_ADDU));        // Reads $zero back
        prog.push_back(HALT_WORD);
    endtask

    task automatic build_step_program();
        prog.delete();
        for (int i = 1; i <= HALT_AT; i++) begin
            prog.push_back(make_itype(`OP_ADDIU, 5'(i - 1), 5'(i), 16'($random(seed))));
        end
        prog.push_back(HALT_WORD);
        for (int i = 1; i < STEP_LEN - HALT_AT; i++) begin
            prog.push_back(make_itype(`OP_ORI, 5'd0, 5'(i), 16'hffff));  // Must never retire
        end
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        restart        = 1'b0;
        dunit_clk_en   = 1'b0;
        dunit_reset_pc = 1'b0;
        dunit_w_mem    = 1'b0;
        dunit_addr     = '0;
        dunit_data     = '0;
        reg_chk        = 1'b0;
        exp_reg        = '0;
        halt_chk       = 1'b0;
        exp_halt       = 1'b0;
        reg_errs       = 0;
        halt_errs      = 0;
        wait (rst_n);
        @(negedge clk);
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;               // Reset state
        end
        compare_registers(1'b0);
        build_imm_program();
        run_program(1'b0);
        restart_dut();
        build_rtype_program();
        run_program(1'b0);
        restart_dut();
        build_zero_program();
        run_program(1'b0);
        restart_dut();
        build_step_program();
        run_program(1'b1);
        @(negedge clk);
        $display("Error counts: register readback %0d, halt flag %0d", reg_errs, halt_errs);
        if ((reg_errs == 0) && (halt_errs == 0)) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD = 4,          // 8 ns clock
    parameter int RST_CYCLES  = 10
) (
    input  wire logic i_restart,            // Rising edge starts a new reset
    output logic      o_clk,
    output logic      o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;
    end

    // Reset changes on falling edges, like the rest of the stimulus
    initial begin
        o_rst_n = 1'b0;
        forever begin
            repeat (RST_CYCLES) @(posedge o_clk);
            @(negedge o_clk);
            o_rst_n = 1'b1;
            @(posedge i_restart);
            o_rst_n = 1'b0;                 // Held again for RST_CYCLES
        end
    end

endmodule

`default_nettype wire

// File: hdl/mips_pipeline.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_defines.svh"

module mips_pipeline (
    input  wire logic                 i_clk,
    input  wire logic                 i_rst_n,
    input  wire logic                 i_dunit_clk_en,   // Advances every stage
    input  wire logic                 i_dunit_reset_pc,
    input  wire logic                 i_dunit_w_mem,    // Instruction memory load
    input  wire logic [`REG_W-1:0]    i_dunit_addr,     // imem word or register index
    input  wire logic [`REG_W-1:0]    i_dunit_data,
    output logic      [`REG_W-1:0]    o_dunit_reg,      // Register readback
    output logic                      o_halt
);

    // --------------------------------------------------
    // Stage wiring
    // --------------------------------------------------
    mips_pkg::instr_t    ifid_instr;
    logic                ifid_valid;
    logic                halt_seen;
    logic [`REG_W-1:0]   idex_op_a;
    logic [`REG_W-1:0]   idex_op_b;
    logic [`ALU_W-1:0]   idex_alu_sel;
    logic [`RADDR_W-1:0] idex_dest;
    logic                idex_wr_en;
    logic                idex_is_halt;
    logic                wb_en;
    logic [`RADDR_W-1:0] wb_addr;
    logic [`REG_W-1:0]   wb_data;

    fetch_stage u_fetch (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_dunit_clk_en  (i_dunit_clk_en),
        .i_dunit_reset_pc(i_dunit_reset_pc),
        .i_dunit_w_mem   (i_dunit_w_mem),
        .i_dunit_addr    (i_dunit_addr),
        .i_dunit_data    (i_dunit_data),
        .i_halt_seen     (halt_seen),
        .o_instr         (ifid_instr),
        .o_valid         (ifid_valid)
    );

    decode_stage u_decode (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_dunit_clk_en(i_dunit_clk_en),
        .i_instr       (ifid_instr),
        .i_valid       (ifid_valid),
        .i_wb_en       (wb_en),
        .i_wb_addr     (wb_addr),
        .i_wb_data     (wb_data),
        .i_dbg_addr    (i_dunit_addr[`RADDR_W-1:0]),   // Low bits pick the register
        .o_halt_seen   (halt_seen),
        .o_op_a        (idex_op_a),
        .o_op_b        (idex_op_b),
        .o_alu_sel     (idex_alu_sel),
        .o_dest        (idex_dest),
        .o_wr_en       (idex_wr_en),
        .o_is_halt     (idex_is_halt),
        .o_dbg_data    (o_dunit_reg)
    );

    execute_stage u_execute (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_dunit_clk_en(i_dunit_clk_en),
        .i_op_a        (idex_op_a),
        .i_op_b        (idex_op_b),
        .i_alu_sel     (idex_alu_sel),
        .i_dest        (idex_dest),
        .i_wr_en       (idex_wr_en),
        .i_is_halt     (idex_is_halt),
        .o_wb_en       (wb_en),
        .o_wb_addr     (wb_addr),
        .o_wb_data     (wb_data),
        .o_halt        (o_halt)
    );

endmodule

`default_nettype wire

// File: hdl/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_defines.svh"

module execute_stage (
    input  wire logic                 i_clk,
    input  wire logic                 i_rst_n,
    input  wire logic                 i_dunit_clk_en,
    input  wire logic [`REG_W-1:0]    i_op_a,       // From ID/EX
    input  wire logic [`REG_W-1:0]    i_op_b,
    input  wire logic [`ALU_W-1:0]    i_alu_sel,
    input  wire logic [`RADDR_W-1:0]  i_dest,
    input  wire logic                 i_wr_en,
    input  wire logic                 i_is_halt,
    output logic                      o_wb_en,      // To the register file
    output logic      [`RADDR_W-1:0]  o_wb_addr,
    output logic      [`REG_W-1:0]    o_wb_data,
    output logic                      o_halt
);

    logic [`REG_W-1:0] alu_res;
    logic              slt_bit;
    logic              halt_q;      // Holds HALT once it has passed

    // --------------------------------------------------
    // ALU
    // --------------------------------------------------
    assign slt_bit = $signed(i_op_a) < $signed(i_op_b);    // Signed compare

    always_comb begin
        case (i_alu_sel)
            `ALU_ADD: alu_res = i_op_a + i_op_b;
            `ALU_SUB: alu_res = i_op_a - i_op_b;
            `ALU_AND: alu_res = i_op_a & i_op_b;
            `ALU_OR:  alu_res = i_op_a | i_op_b;
            `ALU_XOR: alu_res = i_op_a ^ i_op_b;
            `ALU_SLT: alu_res = {{(`REG_W-1){1'b0}}, slt_bit};
            `ALU_LUI: alu_res = i_op_b << 16;           // Immediate into upper half
            default:  alu_res = '0;
        endcase
    end

    // Write-back lands on the next enabled edge
    assign o_wb_en   = i_wr_en && i_dunit_clk_en;
    assign o_wb_addr = i_dest;
    assign o_wb_data = alu_res;

    // --------------------------------------------------
    // Halt flag
    // --------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            halt_q <= 1'b0;
        end else if (i_dunit_clk_en && i_is_halt) begin
            halt_q <= 1'b1;                 // Sticky until reset
        end
    end

    assign o_halt = halt_q || i_is_halt;    // Up as soon as ID/EX takes HALT

    a_halt_sticky : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_halt |=> o_halt
    ) else $error("o_halt dropped without reset");

endmodule

`default_nettype wire

// File: hdl/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_defines.svh"

module decode_stage (
    input  wire logic                 i_clk,
    input  wire logic                 i_rst_n,
    input  wire logic                 i_dunit_clk_en,
    input  wire mips_pkg::instr_t     i_instr,      // From IF/ID
    input  wire logic                 i_valid,
    input  wire logic                 i_wb_en,      // Write-back from execute
    input  wire logic [`RADDR_W-1:0]  i_wb_addr,
    input  wire logic [`REG_W-1:0]    i_wb_data,
    input  wire logic [`RADDR_W-1:0]  i_dbg_addr,
    output logic                      o_halt_seen,  // Back to fetch
    output logic      [`REG_W-1:0]    o_op_a,       // ID/EX outputs
    output logic      [`REG_W-1:0]    o_op_b,
    output logic      [`ALU_W-1:0]    o_alu_sel,
    output logic      [`RADDR_W-1:0]  o_dest,
    output logic                      o_wr_en,
    output logic                      o_is_halt,
    output logic      [`REG_W-1:0]    o_dbg_data
);

    logic [`REG_W-1:0]   rs_data;
    logic [`REG_W-1:0]   rt_data;
    logic [`REG_W-1:0]   imm_sext;
    logic [`REG_W-1:0]   imm_zext;
    logic [`REG_W-1:0]   dec_op_b;
    logic [`ALU_W-1:0]   dec_alu_sel;
    logic [`RADDR_W-1:0] dec_dest;
    logic                dec_wr;
    logic                halt_passed;   // HALT has already left ID/EX
    logic                bubble;

    register_file u_register_file (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_rs_addr (i_instr.r.rs),
        .i_rt_addr (i_instr.r.rt),
        .i_wr_en   (i_wb_en),
        .i_wr_addr (i_wb_addr),
        .i_wr_data (i_wb_data),
        .i_dbg_addr(i_dbg_addr),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data),
        .o_dbg_data(o_dbg_data)
    );

    assign imm_sext    = {{(`REG_W-16){i_instr.i.imm16[15]}}, i_instr.i.imm16};
    assign imm_zext    = {{(`REG_W-16){1'b0}}, i_instr.i.imm16};
    assign o_halt_seen = i_valid && (i_instr.r.op == `OP_HALT);

    // --------------------------------------------------
    // Control decode
    // --------------------------------------------------
    always_comb begin
        dec_op_b    = rt_data;
        dec_alu_sel = `ALU_ADD;
        dec_dest    = i_instr.i.rt;             // I-type default
        dec_wr      = 1'b0;
        case (i_instr.r.op)
            `OP_RTYPE: begin
                dec_dest = i_instr.r.rd;
                dec_wr   = 1'b1;
                case (i_instr.r.funct)
                    `FN_ADDU: dec_alu_sel = `ALU_ADD;
                    `FN_SUBU: dec_alu_sel = `ALU_SUB;
                    `FN_AND:  dec_alu_sel = `ALU_AND;
                    `FN_OR:   dec_alu_sel = `ALU_OR;
                    `FN_XOR:  dec_alu_sel = `ALU_XOR;
                    `FN_SLT:  dec_alu_sel = `ALU_SLT;
                    default:  dec_wr      = 1'b0;   // Unknown funct is a no-op
                endcase
            end
            `OP_ADDIU: begin
                dec_op_b    = imm_sext;
                dec_alu_sel = `ALU_ADD;
                dec_wr      = 1'b1;
            end
            `OP_ANDI: begin
                dec_op_b    = imm_zext;
                dec_alu_sel = `ALU_AND;
                dec_wr      = 1'b1;
            end
            `OP_ORI: begin
                dec_op_b    = imm_zext;
                dec_alu_sel = `ALU_OR;
                dec_wr      = 1'b1;
            end
            `OP_LUI: begin
                dec_op_b    = imm_zext;         // Shifted up in execute
                dec_alu_sel = `ALU_LUI;
                dec_wr      = 1'b1;
            end
            default: dec_wr = 1'b0;             // HALT and unknown ops write nothing
        endcase
    end

    assign bubble = o_is_halt || halt_passed;   // Nothing follows HALT

    // --------------------------------------------------
    // ID/EX register
    // --------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wr_en     <= 1'b0;
            o_is_halt   <= 1'b0;
            halt_passed <= 1'b0;
        end else if (i_dunit_clk_en) begin
            o_wr_en     <= !bubble && i_valid && dec_wr && (dec_dest != '0);
            o_is_halt   <= !bubble && o_halt_seen;
            halt_passed <= halt_passed || o_is_halt;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_dunit_clk_en) begin
            o_op_a    <= rs_data;
            o_op_b    <= dec_op_b;
            o_alu_sel <= dec_alu_sel;
            o_dest    <= dec_dest;
        end
    end

    a_no_write_to_zero : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_wr_en |-> (o_dest != '0)
    ) else $error("ID/EX write enable set for register zero");

endmodule

`default_nettype wire

// File: hdl/register_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_defines.svh"

module register_file (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst_n,
    input  wire logic [`RADDR_W-1:0]   i_rs_addr,
    input  wire logic [`RADDR_W-1:0]   i_rt_addr,
    input  wire logic                  i_wr_en,     // Already gated by the step enable
    input  wire logic [`RADDR_W-1:0]   i_wr_addr,
    input  wire logic [`REG_W-1:0]     i_wr_data,
    input  wire logic [`RADDR_W-1:0]   i_dbg_addr,  // Debug unit readback
    output logic      [`REG_W-1:0]     o_rs_data,
    output logic      [`REG_W-1:0]     o_rt_data,
    output logic      [`REG_W-1:0]     o_dbg_data
);

    localparam int NUM_REGS = 1 << `RADDR_W;

    logic [`REG_W-1:0] regs [NUM_REGS];
    logic              wr_live;

    assign wr_live = i_wr_en && (i_wr_addr != '0);  // $zero is never written

    // --------------------------------------------------
    // Write port
    // --------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // Operand read with write-through
    // A write in flight this cycle is seen by decode at once
    function automatic logic [`REG_W-1:0] read_port(input logic [`RADDR_W-1:0] addr);
        logic [`REG_W-1:0] data;
        if (addr == '0) begin
            data = '0;
        end else if (wr_live && (addr == i_wr_addr)) begin
            data = i_wr_data;               // Bypass
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_comb begin
        o_rs_data = read_port(i_rs_addr);
        o_rt_data = read_port(i_rt_addr);
    end

    assign o_dbg_data = (i_dbg_addr == '0) ? '0 : regs[i_dbg_addr];  // Stored value only

endmodule

`default_nettype wire

// File: hdl/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_defines.svh"

module fetch_stage (
    input  wire logic                 i_clk,
    input  wire logic                 i_rst_n,
    input  wire logic                 i_dunit_clk_en,   // Single step enable
    input  wire logic                 i_dunit_reset_pc, // Restart from word 0
    input  wire logic                 i_dunit_w_mem,    // Debug write to imem
    input  wire logic [`REG_W-1:0]    i_dunit_addr,     // Word address of debug write
    input  wire logic [`REG_W-1:0]    i_dunit_data,     // Instruction to store
    input  wire logic                 i_halt_seen,      // HALT waiting in IF/ID
    output mips_pkg::instr_t          o_instr,          // IF/ID instruction
    output logic                      o_valid           // IF/ID holds a real word
);

    localparam int IMEM_DEPTH = 1 << `IMEM_AW;

    logic [`REG_W-1:0]   imem [IMEM_DEPTH];  // Instruction memory
    logic [`IMEM_AW-1:0] pc;                 // Word index, not byte address
    logic                advance;

    // --------------------------------------------------
    // Debug load port
    // --------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_dunit_w_mem) begin
            imem[i_dunit_addr[`IMEM_AW-1:0]] <= i_dunit_data;   // Upper bits ignored
        end
    end

    assign advance = i_dunit_clk_en && !i_halt_seen;    // HALT freezes the front end

    // --------------------------------------------------
    // PC and IF/ID register
    // --------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc      <= '0;
            o_valid <= 1'b0;
        end else if (i_dunit_reset_pc) begin
            pc      <= '0;                  // Wins over the enable
            o_valid <= 1'b0;
        end else if (advance) begin
            pc      <= pc + 1'b1;           // Next word
            o_valid <= 1'b1;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_instr <= '0;
        end else if (advance && !i_dunit_reset_pc) begin
            o_instr <= imem[pc];            // Raw word into the union
        end
    end

    // Loading and stepping must not overlap
    a_no_load_while_running : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !(i_dunit_w_mem && i_dunit_clk_en)
    ) else $error("imem debug write while the pipeline is enabled");

endmodule

`default_nettype wire

// File: hdl/mips_pkg.sv
`default_nettype none

`include "mips_defines.svh"

package mips_pkg;

    // --------------------------------------------------
    // Instruction field layouts
    // --------------------------------------------------

    // R-type register to register format
    typedef struct packed {
        logic [5:0]          op;        // Always OP_RTYPE
        logic [`RADDR_W-1:0] rs;        // Operand A register
        logic [`RADDR_W-1:0] rt;        // Operand B register
        logic [`RADDR_W-1:0] rd;        // Destination
        logic [`RADDR_W-1:0] shamt;     // Shift amount
        logic [5:0]          funct;     // Selects the ALU operation
    } r_fmt_t;

    // I-type immediate format
    typedef struct packed {
        logic [5:0]          op;        // Opcode
        logic [`RADDR_W-1:0] rs;        // Operand A register
        logic [`RADDR_W-1:0] rt;        // Destination
        logic [15:0]         imm16;     // Sign or zero extended by decode
    } i_fmt_t;

    // --------------------------------------------------
    // One word seen through either layout
    // --------------------------------------------------
    typedef union packed {
        r_fmt_t r;                      // Read for opcode 0
        i_fmt_t i;                      // Read for immediate ops
    } instr_t;

endpackage

`default_nettype wire

// File: hdl/mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

`define REG_W     32            // Data and instruction word
`define RADDR_W   5             // Register index
`define IMEM_AW   9             // Instruction memory word index

`define OP_RTYPE  6'h00
`define OP_ADDIU  6'h09
`define OP_ANDI   6'h0c
`define OP_ORI    6'h0d
`define OP_LUI    6'h0f
`define OP_HALT   6'h3f         // Stops fetch and raises o_halt

`define FN_ADDU   6'h21
`define FN_SUBU   6'h23
`define FN_AND    6'h24
`define FN_OR     6'h25
`define FN_XOR    6'h26
`define FN_SLT    6'h2a

`define ALU_W     3
`define ALU_ADD   3'd0
`define ALU_SUB   3'd1
`define ALU_AND   3'd2
`define ALU_OR    3'd3
`define ALU_XOR   3'd4
`define ALU_SLT   3'd5
`define ALU_LUI   3'd6

`endif
